/* graph_pkg.sv */
`default_nettype none

package graph_pkg;

    // Lattice extent, columns by rows by measurement rounds
    localparam int GRID_WIDTH_X = 3;
    localparam int GRID_WIDTH_Z = 2;
    localparam int GRID_WIDTH_U = 2;

    localparam int X_BIT_WIDTH = 2;
    localparam int Z_BIT_WIDTH = 1;
    localparam int U_BIT_WIDTH = 1;
    localparam int ADDRESS_WIDTH = X_BIT_WIDTH + Z_BIT_WIDTH + U_BIT_WIDTH;

    // Address layout {u, x, z}, so smaller means earlier round first
    typedef logic [ADDRESS_WIDTH-1:0] addr_t;

    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_COUNT_PER_ROUND * GRID_WIDTH_U;

    // Neighbor slots, each pair differs only in bit 0
    localparam int NEIGHBOR_COUNT = 6;
    localparam int DIR_NORTH = 0;  // x - 1
    localparam int DIR_SOUTH = 1;  // x + 1
    localparam int DIR_WEST = 2;   // z - 1
    localparam int DIR_EAST = 3;   // z + 1
    localparam int DIR_DOWN = 4;   // u - 1
    localparam int DIR_UP = 5;     // u + 1

    typedef logic [1:0] growth_t;
    localparam growth_t LINK_WEIGHT = 2'd2;  // Same weight on every edge

    // Unit index in the flat arrays
    // Same order as the address, with the unused x code left out
    function automatic int unit_index(input int x, input int z, input int u);
        return x * GRID_WIDTH_Z + z + u * PU_COUNT_PER_ROUND;
    endfunction

    function automatic addr_t pu_address(input int x, input int z, input int u);
        return {U_BIT_WIDTH'(u), X_BIT_WIDTH'(x), Z_BIT_WIDTH'(z)};
    endfunction

endpackage

`default_nettype wire

/* stage_pkg.sv */
`default_nettype none

package stage_pkg;

    // Global decoder stage, driven from outside the graph
    typedef enum logic [2:0] {
        STAGE_IDLE = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW = 3'd2,
        STAGE_MERGE = 3'd3
    } stage_t;

endpackage

`default_nettype wire

/* neighbor_link.sv */
`default_nettype none

module neighbor_link
    import graph_pkg::*;
    import stage_pkg::*;
#(
    parameter bit LINK_EXISTS = 1'b1  // Zero for a fake edge at the lattice border
) (
    input wire clk,
    input wire reset,
    input wire stage_t global_stage_i,
    input wire a_increase_i,
    input wire b_increase_i,
    output logic fully_grown_o
);

    growth_t growth;
    logic [2:0] growth_sum;

    // Both end units may push in the same grow cycle
    always_comb begin
        growth_sum = {1'b0, growth} + {2'b00, a_increase_i} + {2'b00, b_increase_i};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else if (!LINK_EXISTS) begin
            growth <= '0;  // Fake edge never grows
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: begin
                    growth <= '0;
                end
                STAGE_GROW: begin
                    if (growth_sum >= {1'b0, LINK_WEIGHT}) begin
                        growth <= LINK_WEIGHT;
                    end else begin
                        growth <= growth_sum[1:0];
                    end
                end
                default: begin
                    growth <= growth;
                end
            endcase
        end
    end

    // Valid in the first cycle after the grow edge
    assign fully_grown_o = (growth == LINK_WEIGHT);

endmodule

`default_nettype wire

/* processing_unit.sv */
`default_nettype none

module processing_unit
    import graph_pkg::*;
    import stage_pkg::*;
#(
    parameter addr_t PU_ADDRESS = '0
) (
    input wire clk,
    input wire reset,
    input wire stage_t global_stage_i,
    input wire measurement_i,
    output logic measurement_o,
    input wire [NEIGHBOR_COUNT-1:0] neighbor_fully_grown_i,
    input wire addr_t neighbor_root_i [NEIGHBOR_COUNT],
    input wire odd_i,
    output addr_t root_o,
    output logic defect_o,
    output logic increase_o,
    output logic busy_o
);

    logic defect;
    addr_t root;
    addr_t min_root;
    logic busy;

    // Smallest root reachable over one fully grown edge
    always_comb begin
        min_root = root;
        for (int d = 0; d < NEIGHBOR_COUNT; d++) begin
            if (neighbor_fully_grown_i[d] && (neighbor_root_i[d] < min_root)) begin
                min_root = neighbor_root_i[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defect <= 1'b0;
            root <= PU_ADDRESS;
            busy <= 1'b0;
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: begin
                    defect <= measurement_i;  // Old value moves one layer down
                    root <= PU_ADDRESS;
                    busy <= 1'b0;
                end
                STAGE_GROW: begin
                    busy <= 1'b0;
                end
                STAGE_MERGE: begin
                    root <= min_root;
                    busy <= (min_root != root);
                end
                default: begin
                    // Idle holds everything
                    defect <= defect;
                    root <= root;
                    busy <= busy;
                end
            endcase
        end
    end

    assign measurement_o = defect;
    assign defect_o = defect;
    assign root_o = root;
    assign busy_o = busy;

    // Odd clusters keep growing, even ones stay put
    assign increase_o = odd_i;

endmodule

`default_nettype wire

/* cluster_parity.sv */
`default_nettype none

module cluster_parity
    import graph_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire addr_t roots_i [PU_COUNT],
    input wire [PU_COUNT-1:0] defects_i,
    output logic [PU_COUNT-1:0] odd_o
);

    logic [PU_COUNT-1:0] parity;

    // Defect count parity of the cluster each unit belongs to
    always_comb begin
        for (int i = 0; i < PU_COUNT; i++) begin
            parity[i] = 1'b0;
            for (int j = 0; j < PU_COUNT; j++) begin
                if (roots_i[j] == roots_i[i]) begin
                    parity[i] = parity[i] ^ defects_i[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            odd_o <= '0;
        end else begin
            odd_o <= parity;  // One cycle behind roots and defects
        end
    end

endmodule

`default_nettype wire

/* decoding_graph.sv */
`default_nettype none

module decoding_graph
    import graph_pkg::*;
    import stage_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire [PU_COUNT_PER_ROUND-1:0] measurements_i,
    input wire stage_t global_stage_i,
    output wire addr_t roots_o [PU_COUNT],
    output wire [PU_COUNT-1:0] odd_clusters_o,
    output wire [PU_COUNT-1:0] busy_o
);

    wire [PU_COUNT-1:0] increase;
    wire [PU_COUNT-1:0] defect;
    wire [PU_COUNT-1:0] meas_chain;  // measurement_o of every unit
    wire [PU_COUNT-1:0][NEIGHBOR_COUNT-1:0] slot_grown;

    genvar u, x, z, d;

    for (u = 0; u < GRID_WIDTH_U; u++) begin : g_u
        for (x = 0; x < GRID_WIDTH_X; x++) begin : g_x
            for (z = 0; z < GRID_WIDTH_Z; z++) begin : g_z
                localparam int IDX = unit_index(x, z, u);

                wire meas_in;
                wire addr_t nb_root [NEIGHBOR_COUNT];

                // Top layer loads from outside, lower layers from above
                if (u == GRID_WIDTH_U - 1) begin : g_top
                    assign meas_in = measurements_i[unit_index(x, z, 0)];
                end else begin : g_lower
                    assign meas_in = meas_chain[unit_index(x, z, u + 1)];
                end

                processing_unit #(
                    .PU_ADDRESS(pu_address(x, z, u))
                ) pu (
                    .clk(clk),
                    .reset(reset),
                    .global_stage_i(global_stage_i),
                    .measurement_i(meas_in),
                    .measurement_o(meas_chain[IDX]),
                    .neighbor_fully_grown_i(slot_grown[IDX]),
                    .neighbor_root_i(nb_root),
                    .odd_i(odd_clusters_o[IDX]),
                    .root_o(roots_o[IDX]),
                    .defect_o(defect[IDX]),
                    .increase_o(increase[IDX]),
                    .busy_o(busy_o[IDX])
                );

                for (d = 0; d < NEIGHBOR_COUNT; d++) begin : g_slot
                    // Coordinates of the unit behind this slot
                    localparam int NX = x + ((d == DIR_SOUTH) ? 1 : 0)
                                          - ((d == DIR_NORTH) ? 1 : 0);
                    localparam int NZ = z + ((d == DIR_EAST) ? 1 : 0)
                                          - ((d == DIR_WEST) ? 1 : 0);
                    localparam int NU = u + ((d == DIR_UP) ? 1 : 0)
                                          - ((d == DIR_DOWN) ? 1 : 0);
                    localparam bit HAS_NB = (NX >= 0) && (NX < GRID_WIDTH_X)
                                         && (NZ >= 0) && (NZ < GRID_WIDTH_Z)
                                         && (NU >= 0) && (NU < GRID_WIDTH_U);
                    localparam int NB = unit_index(NX, NZ, NU);
                    localparam int OPP = d ^ 1;

                    if (HAS_NB) begin : g_root_nb
                        assign nb_root[d] = roots_o[NB];
                    end else begin : g_root_self
                        assign nb_root[d] = roots_o[IDX];  // Border slot sees own root
                    end

                    if (!HAS_NB) begin : g_fake
                        neighbor_link #(
                            .LINK_EXISTS(1'b0)
                        ) link (
                            .clk(clk),
                            .reset(reset),
                            .global_stage_i(global_stage_i),
                            .a_increase_i(increase[IDX]),
                            .b_increase_i(1'b0),
                            .fully_grown_o(slot_grown[IDX][d])
                        );
                    end else if ((d % 2) == 1) begin : g_edge
                        // Real edge owned by the lower end, shared with the upper end
                        wire grown;

                        neighbor_link #(
                            .LINK_EXISTS(1'b1)
                        ) link (
                            .clk(clk),
                            .reset(reset),
                            .global_stage_i(global_stage_i),
                            .a_increase_i(increase[IDX]),
                            .b_increase_i(increase[NB]),
                            .fully_grown_o(grown)
                        );

                        assign slot_grown[IDX][d] = grown;
                        assign slot_grown[NB][OPP] = grown;
                    end
                end
            end
        end
    end

    cluster_parity parity (
        .clk(clk),
        .reset(reset),
        .roots_i(roots_o),
        .defects_i(defect),
        .odd_o(odd_clusters_o)
    );

endmodule

`default_nettype wire

/* decoding_graph_model.svh */
`ifndef DECODING_GRAPH_MODEL_SVH
`define DECODING_GRAPH_MODEL_SVH

typedef logic [PU_COUNT-1:0][ADDRESS_WIDTH-1:0] root_vec_t;

// Unit behind slot d of unit idx, or -1 where the slot leaves the lattice
function automatic int neighbor_index(input int idx, input int d);
    int u;
    int x;
    int z;
    u = idx / PU_COUNT_PER_ROUND;
    x = (idx % PU_COUNT_PER_ROUND) / GRID_WIDTH_Z;
    z = idx % GRID_WIDTH_Z;
    case (d)
        DIR_NORTH: x = x - 1;
        DIR_SOUTH: x = x + 1;
        DIR_WEST: z = z - 1;
        DIR_EAST: z = z + 1;
        DIR_DOWN: u = u - 1;
        default: u = u + 1;
    endcase
    if (x < 0 || x >= GRID_WIDTH_X || z < 0 || z >= GRID_WIDTH_Z) begin
        return -1;
    end
    if (u < 0 || u >= GRID_WIDTH_U) begin
        return -1;
    end
    return x * GRID_WIDTH_Z + z + u * PU_COUNT_PER_ROUND;
endfunction

// Vertex address of a unit, u field on top, then x, then z
function automatic addr_t index_to_address(input int idx);
    int u;
    int x;
    int z;
    u = idx / PU_COUNT_PER_ROUND;
    x = (idx % PU_COUNT_PER_ROUND) / GRID_WIDTH_Z;
    z = idx % GRID_WIDTH_Z;
    return ADDRESS_WIDTH'((u << (X_BIT_WIDTH + Z_BIT_WIDTH)) + (x << Z_BIT_WIDTH) + z);
endfunction

// Expected roots and odd flags after a number of grow and merge rounds
function automatic void model_decode(
    input logic [PU_COUNT-1:0] syndrome,
    input int grow_rounds,
    output root_vec_t roots,
    output logic [PU_COUNT-1:0] odd,
    output bit all_grown
);
    int growth [PU_COUNT][NEIGHBOR_COUNT];
    int root [PU_COUNT];
    int nb;
    bit changed;
    for (int i = 0; i < PU_COUNT; i++) begin
        root[i] = i;
        for (int d = 0; d < NEIGHBOR_COUNT; d++) begin
            growth[i][d] = 0;
        end
    end
    for (int r = 0; r <= grow_rounds; r++) begin
        // Defect parity of each component
        for (int i = 0; i < PU_COUNT; i++) begin
            odd[i] = 1'b0;
            for (int j = 0; j < PU_COUNT; j++) begin
                if (root[j] == root[i]) begin
                    odd[i] = odd[i] ^ syndrome[j];
                end
            end
        end
        if (r < grow_rounds) begin
            // Edge kept at its lower end, in the upward slots
            for (int i = 0; i < PU_COUNT; i++) begin
                for (int d = 1; d < NEIGHBOR_COUNT; d += 2) begin
                    nb = neighbor_index(i, d);
                    if (nb >= 0) begin
                        growth[i][d] = growth[i][d] + int'(odd[i]) + int'(odd[nb]);
                        if (growth[i][d] > int'(LINK_WEIGHT)) begin
                            growth[i][d] = int'(LINK_WEIGHT);
                        end
                    end
                end
            end
            // Smallest index spreads over fully grown edges
            do begin
                changed = 1'b0;
                for (int i = 0; i < PU_COUNT; i++) begin
                    for (int d = 1; d < NEIGHBOR_COUNT; d += 2) begin
                        nb = neighbor_index(i, d);
                        if (nb >= 0 && growth[i][d] == int'(LINK_WEIGHT)
                                && root[i] != root[nb]) begin
                            if (root[nb] < root[i]) begin
                                root[i] = root[nb];
                            end else begin
                                root[nb] = root[i];
                            end
                            changed = 1'b1;
                        end
                    end
                end
            end while (changed);
        end
    end
    all_grown = 1'b1;
    for (int i = 0; i < PU_COUNT; i++) begin
        roots[i] = index_to_address(root[i]);  // Smallest index is also smallest address
        for (int d = 1; d < NEIGHBOR_COUNT; d += 2) begin
            if (neighbor_index(i, d) >= 0 && growth[i][d] != int'(LINK_WEIGHT)) begin
                all_grown = 1'b0;
            end
        end
    end
endfunction

`endif

/* decoding_graph_tb.sv */
`default_nettype none

module decoding_graph_tb
    import graph_pkg::*;
    import stage_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_COUNT = 50;
    localparam int MAX_GROW_ROUNDS = 10;
    localparam int DIRECTED_ROUNDS = 8;
    localparam int WATCHDOG_CYCLES =
        200 * (RANDOM_COUNT * (MAX_GROW_ROUNDS + 1) + DIRECTED_ROUNDS);

    `include "decoding_graph_model.svh"

    logic clk;
    logic reset;
    logic [PU_COUNT_PER_ROUND-1:0] measurements;
    stage_t global_stage;
    addr_t roots [PU_COUNT];
    logic [PU_COUNT-1:0] odd_clusters;
    logic [PU_COUNT-1:0] busy;

    // Expected values for the compare process
    root_vec_t exp_roots;
    logic [PU_COUNT-1:0] exp_odd;
    string test_name;
    event check_req;
    int checks_done = 0;
    logic [31:0] rng_state;

    decoding_graph dut0 (
        .clk(clk),
        .reset(reset),
        .measurements_i(measurements),
        .global_stage_i(global_stage),
        .roots_o(roots),
        .odd_clusters_o(odd_clusters),
        .busy_o(busy)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(check_req) begin
        for (int i = 0; i < PU_COUNT; i++) begin
            assert (roots[i] == exp_roots[i]) else
                fail_stop($sformatf("FAILED %s: roots_o[%0d] expected %0d, actual %0d",
                                    test_name, i, exp_roots[i], roots[i]));
        end
        assert (odd_clusters == exp_odd) else
            fail_stop($sformatf("FAILED %s: odd_clusters_o expected %03h, actual %03h",
                                test_name, exp_odd, odd_clusters));
        assert (busy == '0) else
            fail_stop($sformatf("FAILED %s: busy_o expected 000, actual %03h",
                                test_name, busy));
        checks_done = checks_done + 1;
    end

    task automatic request_check(input string name);
        int target;
        target = checks_done + 1;
        test_name = name;
        -> check_req;
        wait (checks_done == target);
    endtask

    task automatic expect_own_roots();
        for (int i = 0; i < PU_COUNT; i++) begin
            exp_roots[i] = index_to_address(i);
        end
    endtask

    // Layer 0 vector goes in first and is pushed down by the second
    task automatic load_syndrome(input logic [PU_COUNT-1:0] syndrome);
        global_stage = STAGE_MEASUREMENT_LOADING;
        measurements = syndrome[PU_COUNT_PER_ROUND-1:0];
        @(negedge clk);
        measurements = syndrome[PU_COUNT-1:PU_COUNT_PER_ROUND];
        @(negedge clk);
        global_stage = STAGE_IDLE;
        measurements = '0;
        @(negedge clk);
    endtask

    task automatic grow_and_merge();
        global_stage = STAGE_GROW;
        @(negedge clk);
        global_stage = STAGE_MERGE;
        @(negedge clk);
        while (busy != '0) begin  // Watchdog bounds this
            @(negedge clk);
        end
        global_stage = STAGE_IDLE;
        @(negedge clk);  // Parity catches up with the final roots
    endtask

    task automatic run_decode(input string name, input logic [PU_COUNT-1:0] syndrome);
        bit all_grown;
        int rounds;
        rounds = 0;
        load_syndrome(syndrome);
        model_decode(syndrome, 0, exp_roots, exp_odd, all_grown);
        request_check($sformatf("%s load", name));
        while (exp_odd != '0 && !all_grown && rounds < MAX_GROW_ROUNDS) begin
            rounds++;
            grow_and_merge();
            model_decode(syndrome, rounds, exp_roots, exp_odd, all_grown);
            request_check($sformatf("%s round %0d", name, rounds));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the decoder never finished", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        measurements = '0;
        global_stage = STAGE_IDLE;
        rng_state = 32'hd30af59c;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        expect_own_roots();
        exp_odd = '0;
        request_check("after_reset");

        // Distinct patterns per layer
        load_syndrome(12'b011010_100101);
        exp_odd = 12'b011010_100101;
        request_check("layer_load");

        // Units 0 and 1 share one edge
        load_syndrome(12'b000000_000011);
        grow_and_merge();
        expect_own_roots();
        exp_roots[1] = 4'd0;
        exp_odd = '0;
        request_check("adjacent_pair");

        // Units 0 and 4 with unit 2 between them
        load_syndrome(12'b000000_010001);
        grow_and_merge();
        expect_own_roots();
        exp_odd = 12'b000000_010001;
        request_check("two_apart round 1");
        grow_and_merge();
        for (int i = 0; i < PU_COUNT; i++) begin
            if (i == 1 || i == 2 || i == 4 || i == 5 || i == 6 || i == 10) begin
                exp_roots[i] = 4'd0;
            end
        end
        exp_odd = '0;
        request_check("two_apart round 2");

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            rng_state = xorshift32(rng_state);
            run_decode($sformatf("random_%0d", n), rng_state[PU_COUNT-1:0]);
        end

        // Fresh load after a decoded syndrome
        load_syndrome(12'b000010_000000);
        expect_own_roots();
        exp_odd = 12'b000010_000000;
        request_check("reload_single");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
graph_pkg.sv
stage_pkg.sv
neighbor_link.sv
processing_unit.sv
cluster_parity.sv
decoding_graph.sv
decoding_graph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decoding graph testbench with Verilator

set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module decoding_graph_tb -f flist.f -o decoding_graph_sim \
    && ./obj_dir/decoding_graph_sim 2>&1 | tee sim.log \
    || echo "Build or simulation ended with an error" | tee -a sim.log

# The log decides, a missing pass line counts as failure
if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
